//--- vlog.f
+incdir+.
isa_pkg.sv
bus_pkg.sv
cpu_alu.sv
cpu_core.sv
test_ram.sv
cpu_system.sv
tb_cpu_system.sv

//--- Bender.yml
package:
  name: cpu_system

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - bus_pkg.sv
      - cpu_alu.sv
      - cpu_core.sv
      - test_ram.sv
      - cpu_system.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu_system.sv

//--- tb_cpu_system.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu_system
	import isa_pkg::*;
();

	// one memory access costs the wait plus the ready cycle
	localparam int ACCESS_CYCLES = `RAM_WAIT_CYCLES + 1;
	// worst instruction has two fetches, execute and one data access
	localparam int INSTR_CYCLES = 3 * ACCESS_CYCLES + 1;
	// five programs of at most 60 instructions
	localparam int RUN_BUDGET = 5 * 60 * INSTR_CYCLES;
	// margin for loading, reset windows and the quiet check
	localparam int CYCLE_LIMIT = 6 * RUN_BUDGET + 2000;
	localparam int RESET_CYCLES = 8;
	localparam int QUIET_CYCLES = 50;

	logic __clk;
	logic rst;
	logic load_we;
	addr_t load_addr;
	data_t load_data;
	logic out_valid;
	data_t out_data;
	logic halted;

	// program image and data cells for the next load
	data_t prog_bytes[$];
	addr_t cell_addr[$];
	data_t cell_data[$];
	// outputs predicted from the ISA rules
	data_t expected[$];
	// outputs seen on the strobe
	data_t collected[$];

	integer seed;
	int error_count;
	int check_count;
	int cycle_count;

	cpu_system DUT
	(
		.__clk(__clk),
		.rst(rst),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.out_valid(out_valid),
		.out_data(out_data),
		.halted(halted)
	);

	// 100 ns period
	always #50 __clk = ~__clk;

	// run limit
	always @(posedge __clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run was stopped after %0d cycles without finishing",
				cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// record every output strobe outside reset
	// values sampled at the edge are the settled pre-edge ones
	always @(posedge __clk)
	begin
		if (!rst && (out_valid === 1'b1))
			collected.push_back(out_data);
	end

	// compare and report one value
	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] want);
		check_count = check_count + 1;
		if (actual !== want)
		begin
			error_count = error_count + 1;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, want);
		end
	endtask

	// empty the image and the prediction
	task automatic start_program();
		prog_bytes.delete();
		cell_addr.delete();
		cell_data.delete();
		expected.delete();
	endtask

	// append one two-byte instruction
	task automatic emit(input opcode_e op, input data_t arg);
		prog_bytes.push_back(data_t'(op));
		prog_bytes.push_back(arg);
	endtask

	// one data byte placed apart from the code
	task automatic set_cell(input addr_t addr, input data_t value);
		cell_addr.push_back(addr);
		cell_data.push_back(value);
	endtask

	task automatic expect_out(input data_t value);
		expected.push_back(value);
	endtask

	// one host port write
	// core must sit in reset
	task automatic host_write(input addr_t addr, input data_t value);
		@(posedge __clk);
		load_we <= 1'b1;
		load_addr <= addr;
		load_data <= value;
	endtask

	// state every output must show while rst is held
	task automatic check_reset_state(input string name);
		check_value({name, " halted in reset"}, halted, 1'b0);
		check_value({name, " out_valid in reset"}, out_valid, 1'b0);
		check_value({name, " bus request in reset"}, DUT.core.mem_req.req, 1'b0);
	endtask

	// hold reset, write image and cells, then release
	task automatic load_program(input string name);
		int i;
		@(posedge __clk);
		rst <= 1'b1;
		load_we <= 1'b0;
		for (i = 0; i < prog_bytes.size(); i++)
			host_write(addr_t'(i), prog_bytes[i]);
		for (i = 0; i < cell_addr.size(); i++)
			host_write(cell_addr[i], cell_data[i]);
		@(posedge __clk);
		load_we <= 1'b0;
		// keep reset a full window after the last write
		repeat (RESET_CYCLES) @(posedge __clk);
		check_reset_state(name);
		collected.delete();
		rst <= 1'b0;
	endtask

	// wait for halt, then compare the strobe record with the prediction
	task automatic run_and_check(input string name);
		int i;
		int n;
		while (halted !== 1'b1)
			@(posedge __clk);
		check_value({name, " output count"}, collected.size(), expected.size());
		n = (collected.size() < expected.size()) ? collected.size() : expected.size();
		for (i = 0; i < n; i++)
			check_value($sformatf("%s output %0d", name, i), collected[i], expected[i]);
	endtask

	// immediate load image
	// the halt and reset run uses it again
	task automatic build_immediate_program();
		start_program();
		emit(OP_LDI, 8'd5);
		emit(OP_OUT, 8'h00);
		emit(OP_LDI, 8'd0);
		emit(OP_OUT, 8'h00);
		emit(OP_HLT, 8'h00);
		expect_out(8'd5);
		expect_out(8'd0);
	endtask

	task automatic immediate_load_out();
		build_immediate_program();
		load_program("immediate");
		run_and_check("immediate");
	endtask

	// store then reload through memory
	task automatic store_load_round_trip();
		start_program();
		emit(OP_LDI, 8'ha5);
		emit(OP_STA, 8'h80);
		emit(OP_LDI, 8'h00);
		emit(OP_LDA, 8'h80);
		emit(OP_OUT, 8'h00);
		emit(OP_HLT, 8'h00);
		expect_out(8'ha5);
		load_program("store/load");
		run_and_check("store/load");
	endtask

	// add, sub and and on two random cells
	task automatic random_arithmetic();
		data_t a;
		data_t b;
		a = data_t'($random(seed));
		b = data_t'($random(seed));
		start_program();
		set_cell(8'h80, a);
		set_cell(8'h81, b);
		emit(OP_LDA, 8'h80);
		emit(OP_ADD, 8'h81);
		emit(OP_OUT, 8'h00);
		emit(OP_LDA, 8'h80);
		emit(OP_SUB, 8'h81);
		emit(OP_OUT, 8'h00);
		emit(OP_LDA, 8'h80);
		emit(OP_AND, 8'h81);
		emit(OP_OUT, 8'h00);
		emit(OP_HLT, 8'h00);
		// results wrap modulo 256
		expect_out(data_t'(a + b));
		expect_out(data_t'(a - b));
		expect_out(a & b);
		load_program("arith");
		run_and_check("arith");
	endtask

	// countdown from 3
	// JZ leaves the loop, JMP closes it
	task automatic countdown_branch_loop();
		start_program();
		set_cell(8'h90, 8'd1);
		emit(OP_LDI, 8'd3);
		// loop head at address 2
		emit(OP_OUT, 8'h00);
		emit(OP_SUB, 8'h90);
		emit(OP_JZ, 8'd10);
		emit(OP_JMP, 8'd2);
		// exit at address 10
		emit(OP_HLT, 8'h00);
		expect_out(8'd3);
		expect_out(8'd2);
		expect_out(8'd1);
		load_program("branch loop");
		run_and_check("branch loop");
	endtask

	// parked after HLT, then a bare reset reruns the kept program
	task automatic halt_then_reset();
		int n;
		build_immediate_program();
		load_program("halt/reset");
		run_and_check("halt/reset first run");
		n = collected.size();
		repeat (QUIET_CYCLES)
		begin
			@(posedge __clk);
			check_value("halted after HLT", halted, 1'b1);
		end
		check_value("strobes after HLT", collected.size(), n);
		// bare reset without host writes
		@(posedge __clk);
		rst <= 1'b1;
		repeat (RESET_CYCLES) @(posedge __clk);
		check_reset_state("halt/reset");
		collected.delete();
		rst <= 1'b0;
		run_and_check("halt/reset rerun");
	endtask

	initial
	begin
		__clk = 1'b0;
		rst = 1'b1;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		seed = 32'h17c6_14e4;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		repeat (RESET_CYCLES) @(posedge __clk);

		immediate_load_out();
		store_load_round_trip();
		random_arithmetic();
		countdown_branch_loop();
		halt_then_reset();

		repeat (2) @(posedge __clk);
		$display("checks: %0d, errors: %0d, cycles: %0d", check_count, error_count,
			cycle_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- cpu_system.sv
`timescale 1ns/1ps

module cpu_system
	import isa_pkg::*;
	import bus_pkg::*;
(
	input logic __clk,
	input logic rst,
	input logic load_we,
	input addr_t load_addr,
	input data_t load_data,
	output logic out_valid,
	output data_t out_data,
	output logic halted
);

	// core to memory bus
	mem_req_t mem_req;
	data_t rdata;
	logic ready;

	cpu_core core
	(
		.__clk(__clk),
		.rst(rst),
		.mem_req(mem_req),
		.rdata(rdata),
		.ready(ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.halted(halted)
	);

	// host port loads program while core sits in reset
	test_ram ram
	(
		.__clk(__clk),
		.rst(rst),
		.mem_req(mem_req),
		.rdata(rdata),
		.ready(ready),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data)
	);

endmodule

//--- test_ram.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module test_ram
	import isa_pkg::*;
	import bus_pkg::*;
(
	input logic __clk,
	input logic rst,
	input mem_req_t mem_req,
	output data_t rdata,
	output logic ready,
	input logic load_we,
	input addr_t load_addr,
	input data_t load_data
);

	localparam int WAIT_CYCLES = `RAM_WAIT_CYCLES;
	localparam int DEPTH = 2 ** `CPU_ADDR_WIDTH;
	// one spare state so a zero wait still gets a real counter
	localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

	data_t mem [DEPTH];
	logic [CNT_W-1:0] wait_cnt;

	// strobe once the count reaches the wait, then restart
	assign ready = mem_req.req && (wait_cnt == CNT_W'(WAIT_CYCLES));

	// async read, valid in the ready cycle
	assign rdata = mem[mem_req.addr];

	// wait counter
	// counts from the first cycle req is seen
	always_ff @(posedge __clk)
	begin
		if (rst)
			wait_cnt <= '0;
		else if (ready)
			wait_cnt <= '0;
		else if (mem_req.req)
			wait_cnt <= wait_cnt + 1'b1;
	end

	// array writes
	// contents kept through rst so a loaded program stays put
	always_ff @(posedge __clk)
	begin
		// core store lands on the ready edge
		if (ready && (mem_req.which == RDWR_WRITE))
			mem[mem_req.addr] <= mem_req.wdata;
		// host port last, it wins a clash
		if (load_we)
			mem[load_addr] <= load_data;
	end

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core
	import isa_pkg::*;
	import bus_pkg::*;
(
	input logic __clk,
	input logic rst,
	output mem_req_t mem_req,
	input data_t rdata,
	input logic ready,
	output logic out_valid,
	output data_t out_data,
	output logic halted
);

	core_state_e state;
	opcode_e opcode;
	data_t operand;
	addr_t pc;
	data_t acc;
	logic zero_flag;
	mem_req_t req_q;
	logic advance;
	logic is_mem_op;
	logic take_jump;
	addr_t next_pc;
	alu_op_e alu_op;
	data_t alu_b;
	data_t alu_result;
	logic alu_zero;

	// build an open request
	function automatic mem_req_t make_req(rdwr_e which, addr_t addr, data_t wdata);
		mem_req_t r;
		r.req = 1'b1;
		r.which = which;
		r.addr = addr;
		r.wdata = wdata;
		return r;
	endfunction

	// freeze while a request is open and memory has not answered
	assign advance = !req_q.req || ready;

	// instructions needing a data access after execute
	assign is_mem_op = (opcode == OP_LDA) || (opcode == OP_STA) || (opcode == OP_ADD)
		|| (opcode == OP_SUB) || (opcode == OP_AND);

	// branch resolution, uses the flag from the previous acc write
	assign take_jump = (opcode == OP_JMP) || ((opcode == OP_JZ) && zero_flag);
	assign next_pc = take_jump ? addr_t'(operand) : pc;

	// opcode to alu function
	// LDI and LDA both use the pass path
	always_comb
	begin
		case (opcode)
			OP_ADD:
				alu_op = ALU_ADD;
			OP_SUB:
				alu_op = ALU_SUB;
			OP_AND:
				alu_op = ALU_AND;
			default:
				alu_op = ALU_PASS;
		endcase
	end

	// memory data in the access state, immediate otherwise
	assign alu_b = (state == MEM_ACCESS) ? rdata : operand;

	cpu_alu alu
	(
		.op(alu_op),
		.a(acc),
		.b(alu_b),
		.result(alu_result),
		.zero(alu_zero)
	);

	always_ff @(posedge __clk)
	begin
		if (rst)
		begin
			state <= FETCH_OP;
			pc <= '0;
			acc <= '0;
			zero_flag <= 1'b0;
			req_q.req <= 1'b0;
		end
		else if (advance)
		begin
			case (state)
				FETCH_OP:
				begin
					if (!req_q.req)
					begin
						// only right after reset, no fetch open yet
						req_q <= make_req(RDWR_READ, pc, acc);
					end
					else
					begin
						opcode <= opcode_e'(rdata);
						pc <= pc + 1'b1;
						// operand fetch goes out back to back
						req_q <= make_req(RDWR_READ, pc + 1'b1, acc);
						state <= FETCH_ARG;
					end
				end
				FETCH_ARG:
				begin
					operand <= rdata;
					pc <= pc + 1'b1;
					req_q.req <= 1'b0;
					state <= EXECUTE;
				end
				EXECUTE:
				begin
					// immediate load
					if (opcode == OP_LDI)
					begin
						acc <= alu_result;
						zero_flag <= alu_zero;
					end
					if (opcode == OP_HLT)
						state <= HALTED;
					else if (is_mem_op)
					begin
						// data access at the operand address
						req_q <= make_req((opcode == OP_STA) ? RDWR_WRITE : RDWR_READ,
							addr_t'(operand), acc);
						state <= MEM_ACCESS;
					end
					else
					begin
						// jumps, OUT, LDI and no-ops
						pc <= next_pc;
						req_q <= make_req(RDWR_READ, next_pc, acc);
						state <= FETCH_OP;
					end
				end
				MEM_ACCESS:
				begin
					// store leaves acc and flag alone
					if (opcode != OP_STA)
					begin
						acc <= alu_result;
						zero_flag <= alu_zero;
					end
					req_q <= make_req(RDWR_READ, pc, acc);
					state <= FETCH_OP;
				end
				HALTED:
				begin
					// parked until rst
					state <= HALTED;
				end
				default:
				begin
					state <= FETCH_OP;
				end
			endcase
		end
	end

	assign mem_req = req_q;

	// output strobe for one execute cycle of OUT
	assign out_valid = (state == EXECUTE) && (opcode == OP_OUT);
	assign out_data = acc;
	assign halted = (state == HALTED);

endmodule

//--- cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu
	import isa_pkg::*;
(
	input alu_op_e op,
	input data_t a,
	input data_t b,
	output data_t result,
	output logic zero
);

	// a is always the accumulator
	// b is the operand byte or the memory read data
	always_comb
	begin
		case (op)
			// add and sub wrap modulo 256
			ALU_ADD:
				result = a + b;
			ALU_SUB:
				result = a - b;
			ALU_AND:
				result = a & b;
			// loads pass b straight through
			default:
				result = b;
		endcase
	end

	// zero flag source for every accumulator write
	assign zero = (result == '0);

endmodule

//--- bus_pkg.sv
package bus_pkg;
	import isa_pkg::*;

	// direction of a memory access
	typedef enum logic
	{
		RDWR_READ = 1'b0,
		RDWR_WRITE = 1'b1
	} rdwr_e;

	// request from core to memory
	// held stable by the core until ready comes back
	typedef struct packed
	{
		// request open
		logic req;
		// read or write
		rdwr_e which;
		// byte address
		addr_t addr;
		// store data, ignored on reads
		data_t wdata;
	} mem_req_t;

endpackage

//--- isa_pkg.sv
`include "cpu_settings.svh"

package isa_pkg;

	// one data byte
	typedef logic [`CPU_DATA_WIDTH-1:0] data_t;

	// one memory address
	typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;

	// first byte of each two-byte instruction
	// codes not listed here execute as no-ops
	typedef enum logic [`CPU_DATA_WIDTH-1:0]
	{
		OP_LDI = 'h01,
		OP_LDA = 'h02,
		OP_STA = 'h03,
		OP_ADD = 'h04,
		OP_SUB = 'h05,
		OP_AND = 'h06,
		OP_JZ  = 'h07,
		OP_JMP = 'h08,
		OP_OUT = 'h09,
		OP_HLT = 'h0a
	} opcode_e;

	// alu function select
	typedef enum logic [1:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_PASS
	} alu_op_e;

	// core sequencing states
	typedef enum logic [2:0]
	{
		FETCH_OP,
		FETCH_ARG,
		EXECUTE,
		MEM_ACCESS,
		HALTED
	} core_state_e;

endpackage

//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// width of one data byte
// also the width of an opcode and of an operand
`define CPU_DATA_WIDTH 8

// address width
// 8 bits gives the full 256-byte space
`define CPU_ADDR_WIDTH 8

// cycles the test memory counts before strobing ready
// an access then lasts this many cycles plus one
`define RAM_WAIT_CYCLES 2

`endif
